/* filelist.f */
radio_tx_reg_pkg.sv
radio_tx_err_pkg.sv
tx_config_regs.sv
tx_burst_fsm.sv
tx_err_fifo.sv
tx_err_reporter.sv
radio_tx_top.sv
tb_radio_tx.sv

/* radio_tx_err_pkg.sv */
`default_nettype none

package radio_tx_err_pkg;

  // ------------------------------------------------------------------
  // Error reporting and stream sideband types
  // ------------------------------------------------------------------

  // Codes written to the error address
  typedef enum logic [3:0] {
    ERR_UNDERRUN  = 4'd1,
    ERR_LATE_DATA = 4'd2,
    ERR_EOB_ACK   = 4'd3
  } err_code_e;

  // One queued event, stamped with radio time at detection
  typedef struct packed {
    err_code_e   code;
    logic [63:0] err_time;
  } err_rec_t;

  // Timed write request towards the error sink
  typedef struct packed {
    logic        wr;
    logic [19:0] addr;
    // Zero-extended error code
    logic [31:0] data;
    logic [63:0] req_time;
    logic [9:0]  portid;
    logic [15:0] rem_epid;
    logic [9:0]  rem_portid;
  } err_req_t;

  // Per-packet fields that travel beside the sample stream
  typedef struct packed {
    logic [63:0] timestamp;
    logic        has_time;
    logic        eob;
  } tx_sideband_t;

endpackage

`default_nettype wire

/* radio_tx_reg_pkg.sv */
`default_nettype none

package radio_tx_reg_pkg;

  // ------------------------------------------------------------------
  // Register map of the transmit channel, byte addresses on the
  // 20-bit control port
  // ------------------------------------------------------------------
  typedef enum logic [19:0] {
    REG_IDLE_VALUE   = 20'h00,
    REG_ERROR_POLICY = 20'h04,
    REG_ERR_PORT     = 20'h08,
    REG_ERR_REM_PORT = 20'h0C,
    REG_ERR_REM_EPID = 20'h10,
    REG_ERR_ADDR     = 20'h14
  } reg_addr_e;

  // Drop scope after an error
  typedef enum logic [1:0] {
    POLICY_PACKET = 2'd0,
    POLICY_BURST  = 2'd1
  } err_policy_e;

  // Control port request, strobes are single cycle
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  // Control port response
  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } ctrlport_resp_t;

  // Where error reports are sent
  typedef struct packed {
    logic [19:0] addr;
    logic [9:0]  portid;
    logic [15:0] rem_epid;
    logic [9:0]  rem_portid;
  } err_route_t;

endpackage

`default_nettype wire

/* radio_tx_top.sv */
`default_nettype none

module radio_tx_top #(
  parameter int SAMP_W          = 32,
  parameter int NSPC            = 1,
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  logic                             radio_clk,
  input  logic                             radio_rst,
  // Control port
  input  radio_tx_reg_pkg::ctrlport_req_t  ctrl_req,
  output radio_tx_reg_pkg::ctrlport_resp_t ctrl_resp,
  // Sample stream
  input  logic [SAMP_W*NSPC-1:0]           s_tdata,
  input  logic                             s_tlast,
  input  logic                             s_tvalid,
  output logic                             s_tready,
  input  radio_tx_err_pkg::tx_sideband_t   s_side,
  // Radio side
  input  logic [63:0]                      radio_time,
  input  logic                             radio_tx_stb,
  output logic [SAMP_W*NSPC-1:0]           radio_tx_data,
  output logic                             radio_tx_running,
  // Error reports
  output radio_tx_err_pkg::err_req_t       err_req,
  input  logic                             err_ack
);

  // ------------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------------
  logic [SAMP_W-1:0]             idle_value;
  radio_tx_reg_pkg::err_policy_e policy;
  radio_tx_reg_pkg::err_route_t  route;
  logic                          err_push;
  radio_tx_err_pkg::err_rec_t    err_rec;
  radio_tx_err_pkg::err_rec_t    head_rec;
  logic                          head_valid;
  logic                          head_pop;

  tx_config_regs #(
    .SAMP_W (SAMP_W),
    .NSPC   (NSPC)
  ) tx_config_regs_i (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .ctrl_req   (ctrl_req),
    .ctrl_resp  (ctrl_resp),
    .idle_value (idle_value),
    .policy     (policy),
    .route      (route)
  );

  tx_burst_fsm #(
    .SAMP_W (SAMP_W),
    .NSPC   (NSPC)
  ) tx_burst_fsm_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .s_tdata          (s_tdata),
    .s_tlast          (s_tlast),
    .s_tvalid         (s_tvalid),
    .s_tready         (s_tready),
    .s_side           (s_side),
    .radio_time       (radio_time),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_running (radio_tx_running),
    .idle_value       (idle_value),
    .policy           (policy),
    .err_push         (err_push),
    .err_rec          (err_rec)
  );

  // Absorbs error bursts while a report is in flight
  tx_err_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) tx_err_fifo_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .push      (err_push),
    .din       (err_rec),
    .pop       (head_pop),
    .dout      (head_rec),
    .valid     (head_valid)
  );

  tx_err_reporter tx_err_reporter_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .rec_valid (head_valid),
    .rec       (head_rec),
    .pop       (head_pop),
    .route     (route),
    .err_req   (err_req),
    .err_ack   (err_ack)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_radio_tx -o tb_radio_tx
./obj_dir/tb_radio_tx

/* tb_radio_tx.sv */
`default_nettype none

module tb_radio_tx;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SAMP_W          = 32;
  localparam int NSPC            = 1;
  localparam int DATA_W          = SAMP_W * NSPC;
  localparam int FIFO_DEPTH_LOG2 = 5;
  localparam int CLK_PERIOD      = 4;

  // ------------------------------------------------------------------
  // Test sizes and the watchdog budget built from them
  // ------------------------------------------------------------------
  localparam int N_BURSTS        = 10;
  localparam int MAX_PKTS        = 3;
  localparam int MAX_LEN         = 8;
  // Each register access takes three cycles
  localparam int REG_OPS         = 16;
  localparam int STIM_WORDS      = REG_OPS * 3 + (N_BURSTS + 5) * MAX_PKTS * MAX_LEN;
  localparam int WATCHDOG_CYCLES = 20 * STIM_WORDS;

  // One stream word plus model bookkeeping
  typedef struct packed {
    logic [DATA_W-1:0]              data;
    logic                           last;
    // Held back until the DUT underruns
    logic                           hold;
    radio_tx_err_pkg::tx_sideband_t side;
  } word_t;

  // Expected report, its time must be above after_time
  typedef struct packed {
    radio_tx_err_pkg::err_code_e code;
    logic [63:0]                 after_time;
  } exp_err_t;

  logic                             radio_clk;
  logic                             radio_rst;
  radio_tx_reg_pkg::ctrlport_req_t  ctrl_req;
  radio_tx_reg_pkg::ctrlport_resp_t ctrl_resp;
  logic [DATA_W-1:0]                s_tdata;
  logic                             s_tlast;
  logic                             s_tvalid;
  logic                             s_tready;
  radio_tx_err_pkg::tx_sideband_t   s_side;
  logic [63:0]                      radio_time;
  logic                             radio_tx_stb;
  logic [DATA_W-1:0]                radio_tx_data;
  logic                             radio_tx_running;
  radio_tx_err_pkg::err_req_t       err_req;
  logic                             err_ack;

  // Reference model state
  word_t                            word_q [$];
  logic [DATA_W-1:0]                exp_samp [$];
  exp_err_t                         exp_err [$];
  radio_tx_reg_pkg::ctrlport_req_t  ctrl_nxt;
  logic [SAMP_W-1:0]                exp_idle;
  logic [1:0]                       exp_policy;
  radio_tx_reg_pkg::err_route_t     exp_route;
  int                               ack_cnt;

  radio_tx_top #(
    .SAMP_W          (SAMP_W),
    .NSPC            (NSPC),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) radio_tx_top_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .ctrl_req         (ctrl_req),
    .ctrl_resp        (ctrl_resp),
    .s_tdata          (s_tdata),
    .s_tlast          (s_tlast),
    .s_tvalid         (s_tvalid),
    .s_tready         (s_tready),
    .s_side           (s_side),
    .radio_time       (radio_time),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_running (radio_tx_running),
    .err_req          (err_req),
    .err_ack          (err_ack)
  );

  initial begin
    radio_clk = 1'b0;
    forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
    abort_run($sformatf("Watchdog expired after %0d cycles, the DUT stopped making progress",
                        WATCHDOG_CYCLES));
  end

  // ------------------------------------------------------------------
  // Failure reporting and checking
  // ------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("** Error [%s] expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic radio_tx_err_pkg::tx_sideband_t make_side(input logic [63:0] ts,
                                                               input logic has_time,
                                                               input logic eob);
    radio_tx_err_pkg::tx_sideband_t s;
    s.timestamp = ts;
    s.has_time  = has_time;
    s.eob       = eob;
    return s;
  endfunction

  // ------------------------------------------------------------------
  // Register model
  // ------------------------------------------------------------------
  function automatic void model_write(input logic [19:0] addr, input logic [31:0] data);
    case (addr)
      radio_tx_reg_pkg::REG_IDLE_VALUE:   exp_idle = data[SAMP_W-1:0];
      // Only the burst encoding survives, all else is packet policy
      radio_tx_reg_pkg::REG_ERROR_POLICY: exp_policy = (data[1:0] == 2'd1) ? 2'd1 : 2'd0;
      radio_tx_reg_pkg::REG_ERR_PORT:     exp_route.portid = data[9:0];
      radio_tx_reg_pkg::REG_ERR_REM_PORT: exp_route.rem_portid = data[9:0];
      radio_tx_reg_pkg::REG_ERR_REM_EPID: exp_route.rem_epid = data[15:0];
      radio_tx_reg_pkg::REG_ERR_ADDR:     exp_route.addr = data[19:0];
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] reg_model(input logic [19:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      radio_tx_reg_pkg::REG_IDLE_VALUE:   v[SAMP_W-1:0] = exp_idle;
      radio_tx_reg_pkg::REG_ERROR_POLICY: v[1:0] = exp_policy;
      radio_tx_reg_pkg::REG_ERR_PORT:     v[9:0] = exp_route.portid;
      radio_tx_reg_pkg::REG_ERR_REM_PORT: v[9:0] = exp_route.rem_portid;
      radio_tx_reg_pkg::REG_ERR_REM_EPID: v[15:0] = exp_route.rem_epid;
      radio_tx_reg_pkg::REG_ERR_ADDR:     v[19:0] = exp_route.addr;
      default: ;
    endcase
    return v;
  endfunction

  // ------------------------------------------------------------------
  // One clock cycle: drive on the falling edge, observe before the rise
  // ------------------------------------------------------------------
  task automatic tick();
    @(negedge radio_clk);
    radio_time   = radio_time + 64'd1;
    radio_tx_stb = ($urandom() % 2) == 1;
    ctrl_req     = ctrl_nxt;
    err_ack      = 1'b0;
    if (ack_cnt > 0) begin
      ack_cnt = ack_cnt - 1;
      err_ack = (ack_cnt == 0);
    end
    if (word_q.size() > 0 && !word_q[0].hold) begin
      s_tvalid = 1'b1;
      s_tdata  = word_q[0].data;
      s_tlast  = word_q[0].last;
      s_side   = word_q[0].side;
    end else begin
      s_tvalid = 1'b0;
      s_tdata  = '0;
      s_tlast  = 1'b0;
      s_side   = '0;
    end
    #1;
    observe();
  endtask

  task automatic observe();
    exp_err_t          e;
    logic [DATA_W-1:0] samp;
    // Idle pattern whenever no live sample is shown
    if (!radio_tx_running || !s_tvalid) begin
      check("idle output", 64'({NSPC{exp_idle}}), 64'(radio_tx_data));
    end
    // Radio strobe paces the stream while transmitting
    if (radio_tx_running) begin
      check("tready", 64'(radio_tx_stb), 64'(s_tready));
    end
    // Timed packet must not run before its timestamp
    if (s_tvalid && s_side.has_time && radio_time < s_side.timestamp) begin
      check("early start", 64'd0, 64'(radio_tx_running));
    end
    if (s_tvalid && s_tready) begin
      if (radio_tx_running) begin
        if (exp_samp.size() == 0) begin
          abort_run("A sample left the radio although the model expected none");
        end else begin
          samp = exp_samp.pop_front();
          check("sample", 64'(samp), 64'(radio_tx_data));
        end
      end
      void'(word_q.pop_front());
    end
    // Starved word is released once the radio strobes into the gap
    if (radio_tx_running && radio_tx_stb && !s_tvalid && word_q.size() > 0) begin
      word_q[0].hold = 1'b0;
    end
    if (err_req.wr) begin
      if (exp_err.size() == 0) begin
        abort_run($sformatf("Unexpected error report with code %0d", err_req.data));
      end else begin
        e = exp_err.pop_front();
        check("report code", 64'(e.code), 64'(err_req.data));
        check("report addr", 64'(exp_route.addr), 64'(err_req.addr));
        check("report portid", 64'(exp_route.portid), 64'(err_req.portid));
        check("report rem_epid", 64'(exp_route.rem_epid), 64'(err_req.rem_epid));
        check("report rem_portid", 64'(exp_route.rem_portid), 64'(err_req.rem_portid));
        check("report time order", 64'd1, 64'(err_req.req_time > e.after_time));
        ack_cnt = $urandom_range(4, 1);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  task automatic reg_access(input logic wr, input logic [19:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata);
    ctrl_nxt.wr   = wr;
    ctrl_nxt.rd   = !wr;
    ctrl_nxt.addr = addr;
    ctrl_nxt.data = data;
    tick();
    check("ack before request", 64'd0, 64'(ctrl_resp.ack));
    ctrl_nxt = '0;
    if (wr) begin
      model_write(addr, data);
    end
    tick();
    check("ack one cycle after request", 64'd1, 64'(ctrl_resp.ack));
    rdata = ctrl_resp.data;
    tick();
    check("ack single cycle", 64'd0, 64'(ctrl_resp.ack));
  endtask

  // First out_words leave the radio, hold_at marks the starved word
  task automatic queue_packet(input int len, input int out_words, input int hold_at,
                              input radio_tx_err_pkg::tx_sideband_t side);
    word_t w;
    for (int i = 0; i < len; i++) begin
      w.data = DATA_W'($urandom());
      w.last = (i == len - 1);
      w.hold = (i == hold_at);
      w.side = side;
      word_q.push_back(w);
      if (i < out_words) begin
        exp_samp.push_back(w.data);
      end
    end
  endtask

  task automatic expect_report(input radio_tx_err_pkg::err_code_e code,
                               input logic [63:0] after_time);
    exp_err_t e;
    e.code       = code;
    e.after_time = after_time;
    exp_err.push_back(e);
  endtask

  task automatic drain();
    // Stream consumed, every expected report seen and acknowledged
    while (word_q.size() > 0 || exp_err.size() > 0 || ack_cnt > 0) begin
      tick();
    end
    // A stray queued record would raise wr within this window
    repeat (3) tick();
    check("samples left", 64'd0, 64'(exp_samp.size()));
    check("reports left", 64'd0, 64'(exp_err.size()));
    check("running after drain", 64'd0, 64'(radio_tx_running));
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    int                         npkts;
    int                         len;
    int                         cut;
    logic [63:0]                ts;
    logic [31:0]                rd;
    radio_tx_reg_pkg::reg_addr_e regs [6];

    void'($urandom(70));
    radio_rst    = 1'b1;
    ctrl_req     = '0;
    ctrl_nxt     = '0;
    s_tdata      = '0;
    s_tlast      = 1'b0;
    s_tvalid     = 1'b0;
    s_side       = '0;
    radio_time   = 64'd1000;
    radio_tx_stb = 1'b0;
    err_ack      = 1'b0;
    exp_idle     = '0;
    exp_policy   = 2'd0;
    exp_route    = '0;
    ack_cnt      = 0;
    regs = '{radio_tx_reg_pkg::REG_IDLE_VALUE, radio_tx_reg_pkg::REG_ERROR_POLICY,
             radio_tx_reg_pkg::REG_ERR_PORT, radio_tx_reg_pkg::REG_ERR_REM_PORT,
             radio_tx_reg_pkg::REG_ERR_REM_EPID, radio_tx_reg_pkg::REG_ERR_ADDR};
    repeat (8) @(negedge radio_clk);
    radio_rst = 1'b0;

    // Registers, random data then an illegal policy code
    for (int i = 0; i < 6; i++) begin
      reg_access(1'b1, regs[i], $urandom(), rd);
    end
    reg_access(1'b1, radio_tx_reg_pkg::REG_ERROR_POLICY, 32'd3, rd);
    for (int i = 0; i < 6; i++) begin
      reg_access(1'b0, regs[i], 32'd0, rd);
      check($sformatf("readback %0h", regs[i]), 64'(reg_model(regs[i])), 64'(rd));
    end

    // Untimed bursts back to back
    for (int b = 0; b < N_BURSTS; b++) begin
      npkts = $urandom_range(MAX_PKTS, 1);
      for (int p = 0; p < npkts; p++) begin
        len = $urandom_range(MAX_LEN, 1);
        queue_packet(len, len, -1, make_side(64'd0, 1'b0, p == npkts - 1));
      end
      expect_report(radio_tx_err_pkg::ERR_EOB_ACK, 64'd0);
    end
    drain();

    // Late packet is dropped, the next one still goes out
    ts  = radio_time - 64'($urandom_range(100, 1));
    len = $urandom_range(MAX_LEN, 1);
    queue_packet(len, 0, -1, make_side(ts, 1'b1, 1'b0));
    expect_report(radio_tx_err_pkg::ERR_LATE_DATA, 64'd0);
    len = $urandom_range(MAX_LEN, 1);
    queue_packet(len, len, -1, make_side(64'd0, 1'b0, 1'b1));
    expect_report(radio_tx_err_pkg::ERR_EOB_ACK, 64'd0);
    drain();

    // Mid-packet underrun drops the rest of the burst
    reg_access(1'b1, radio_tx_reg_pkg::REG_ERROR_POLICY, 32'd1, rd);
    len = $urandom_range(MAX_LEN, 2);
    cut = $urandom_range(len - 1, 1);
    queue_packet(len, cut, cut, make_side(64'd0, 1'b0, 1'b0));
    expect_report(radio_tx_err_pkg::ERR_UNDERRUN, 64'd0);
    queue_packet($urandom_range(MAX_LEN, 1), 0, -1, make_side(64'd0, 1'b0, 1'b0));
    queue_packet($urandom_range(MAX_LEN, 1), 0, -1, make_side(64'd0, 1'b0, 1'b1));
    len = $urandom_range(MAX_LEN, 1);
    queue_packet(len, len, -1, make_side(64'd0, 1'b0, 1'b0));
    len = $urandom_range(MAX_LEN, 1);
    queue_packet(len, len, -1, make_side(64'd0, 1'b0, 1'b1));
    expect_report(radio_tx_err_pkg::ERR_EOB_ACK, 64'd0);
    drain();

    // Future timestamp holds the packet back
    ts  = radio_time + 64'($urandom_range(50, 20));
    len = $urandom_range(MAX_LEN, 1);
    queue_packet(len, len, -1, make_side(ts, 1'b1, 1'b1));
    expect_report(radio_tx_err_pkg::ERR_EOB_ACK, ts);
    drain();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* tx_burst_fsm.sv */
`default_nettype none

module tx_burst_fsm #(
  parameter int SAMP_W = 32,
  parameter int NSPC   = 1
) (
  input  logic                               radio_clk,
  input  logic                               radio_rst,
  // Sample stream
  input  logic [SAMP_W*NSPC-1:0]             s_tdata,
  input  logic                               s_tlast,
  input  logic                               s_tvalid,
  output logic                               s_tready,
  input  radio_tx_err_pkg::tx_sideband_t     s_side,
  // Radio side
  input  logic [63:0]                        radio_time,
  input  logic                               radio_tx_stb,
  output logic [SAMP_W*NSPC-1:0]             radio_tx_data,
  output logic                               radio_tx_running,
  // Configuration
  input  logic [SAMP_W-1:0]                  idle_value,
  input  radio_tx_reg_pkg::err_policy_e      policy,
  // Error events
  output logic                               err_push,
  output radio_tx_err_pkg::err_rec_t         err_rec
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TIME_CHECK,
    ST_TRANSMIT,
    ST_DROP
  } state_e;

  state_e state;
  // Next accepted word opens a packet
  logic   sop;
  logic   time_now;
  logic   time_past;
  logic   late_det;
  logic   under_det;
  logic   eob_det;
  logic   pkt_policy;

  assign pkt_policy = (policy == radio_tx_reg_pkg::POLICY_PACKET);

  // Registered compare keeps the 64-bit compare off the FSM path
  always_ff @(posedge radio_clk) begin
    time_now  <= (radio_time == s_side.timestamp);
    time_past <= (radio_time > s_side.timestamp);
  end

  // ------------------------------------------------------------------
  // Error detection
  // ------------------------------------------------------------------
  // Timed packet whose start time is already gone
  assign late_det  = (state == ST_TIME_CHECK) && s_side.has_time && time_past;
  // Radio asked for a sample and nothing is there
  assign under_det = (state == ST_TRANSMIT) && radio_tx_stb && !s_tvalid;
  // Last word of the burst leaves
  assign eob_det   = (state == ST_TRANSMIT) && radio_tx_stb && s_tvalid && s_tlast && s_side.eob;

  // Record payload, qualified by err_push
  always_ff @(posedge radio_clk) begin
    if (late_det || under_det || eob_det) begin
      err_rec.err_time <= radio_time;
      if (late_det) begin
        err_rec.code <= radio_tx_err_pkg::ERR_LATE_DATA;
      end else if (under_det) begin
        err_rec.code <= radio_tx_err_pkg::ERR_UNDERRUN;
      end else begin
        err_rec.code <= radio_tx_err_pkg::ERR_EOB_ACK;
      end
    end
  end

  // ------------------------------------------------------------------
  // Burst state machine
  // ------------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state    <= ST_IDLE;
      sop      <= 1'b1;
      err_push <= 1'b0;
    end else begin
      err_push <= late_det || under_det || eob_det;
      if (s_tvalid && s_tready) begin
        sop <= s_tlast;
      end

      case (state)
        // One cycle for the time compare to catch up with the new packet
        ST_IDLE: begin
          if (s_tvalid) begin
            state <= ST_TIME_CHECK;
          end
        end
        ST_TIME_CHECK: begin
          if (!s_side.has_time || time_now) begin
            state <= ST_TRANSMIT;
          end else if (late_det) begin
            state <= ST_DROP;
          end
        end
        ST_TRANSMIT: begin
          if (under_det) begin
            state <= ST_DROP;
          end else if (eob_det) begin
            state <= ST_IDLE;
          end
        end
        ST_DROP: begin
          // Packet end, or burst end under burst policy
          if (s_tvalid && s_tlast) begin
            if (pkt_policy || s_side.eob) begin
              state <= ST_IDLE;
            end
          // Underrun landed between packets
          end else if (!s_tvalid && sop && pkt_policy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Live sample while transmitting, idle pattern otherwise
  assign radio_tx_data = (s_tvalid && state == ST_TRANSMIT) ? s_tdata : {NSPC{idle_value}};

  // Strobe-paced in transmit, flush everything in drop
  assign s_tready = (radio_tx_stb && state == ST_TRANSMIT) || (state == ST_DROP);

  assign radio_tx_running = (state == ST_TRANSMIT);

  a_state_legal : assert property (@(posedge radio_clk) disable iff (radio_rst)
    !$isunknown(state) && (state inside {ST_IDLE, ST_TIME_CHECK, ST_TRANSMIT, ST_DROP}));

endmodule

`default_nettype wire

/* tx_config_regs.sv */
`default_nettype none

module tx_config_regs #(
  parameter int SAMP_W = 32,
  parameter int NSPC   = 1
) (
  input  logic                             radio_clk,
  input  logic                             radio_rst,
  input  radio_tx_reg_pkg::ctrlport_req_t  ctrl_req,
  output radio_tx_reg_pkg::ctrlport_resp_t ctrl_resp,
  output logic [SAMP_W-1:0]                idle_value,
  output radio_tx_reg_pkg::err_policy_e    policy,
  output radio_tx_reg_pkg::err_route_t     route
);

  // Idle sample lives in one 32-bit register, at least one sample per cycle
  if (SAMP_W > 32 || NSPC < 1) begin : g_param_check
    $error("tx_config_regs: SAMP_W must be <= 32 and NSPC >= 1");
  end

  // ------------------------------------------------------------------
  // Register writes and reads
  // ------------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      ctrl_resp  <= '0;
      idle_value <= '0;
      policy     <= radio_tx_reg_pkg::POLICY_PACKET;
      route      <= '0;
    end else begin
      // Ack and read data last one cycle
      ctrl_resp <= '0;

      if (ctrl_req.wr) begin
        case (ctrl_req.addr)
          radio_tx_reg_pkg::REG_IDLE_VALUE: begin
            idle_value    <= ctrl_req.data[SAMP_W-1:0];
            ctrl_resp.ack <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERROR_POLICY: begin
            // Unknown encodings fall back to packet policy
            case (ctrl_req.data[1:0])
              radio_tx_reg_pkg::POLICY_BURST: policy <= radio_tx_reg_pkg::POLICY_BURST;
              default:                        policy <= radio_tx_reg_pkg::POLICY_PACKET;
            endcase
            ctrl_resp.ack <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_PORT: begin
            route.portid  <= ctrl_req.data[9:0];
            ctrl_resp.ack <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_REM_PORT: begin
            route.rem_portid <= ctrl_req.data[9:0];
            ctrl_resp.ack    <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_REM_EPID: begin
            route.rem_epid <= ctrl_req.data[15:0];
            ctrl_resp.ack  <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_ADDR: begin
            route.addr    <= ctrl_req.data[19:0];
            ctrl_resp.ack <= 1'b1;
          end
          default: ;
        endcase
      end

      // Unmapped reads get no ack and zero data
      if (ctrl_req.rd) begin
        case (ctrl_req.addr)
          radio_tx_reg_pkg::REG_IDLE_VALUE: begin
            ctrl_resp.data[SAMP_W-1:0] <= idle_value;
            ctrl_resp.ack              <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERROR_POLICY: begin
            ctrl_resp.data[1:0] <= policy;
            ctrl_resp.ack       <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_PORT: begin
            ctrl_resp.data[9:0] <= route.portid;
            ctrl_resp.ack       <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_REM_PORT: begin
            ctrl_resp.data[9:0] <= route.rem_portid;
            ctrl_resp.ack       <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_REM_EPID: begin
            ctrl_resp.data[15:0] <= route.rem_epid;
            ctrl_resp.ack        <= 1'b1;
          end
          radio_tx_reg_pkg::REG_ERR_ADDR: begin
            ctrl_resp.data[19:0] <= route.addr;
            ctrl_resp.ack        <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // A lone strobe yields a single ack cycle
  a_ack_single : assert property (@(posedge radio_clk) disable iff (radio_rst)
    ctrl_resp.ack && !(ctrl_req.wr || ctrl_req.rd) |=> !ctrl_resp.ack);

endmodule

`default_nettype wire

/* tx_err_fifo.sv */
`default_nettype none

module tx_err_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  logic                       push,
  input  radio_tx_err_pkg::err_rec_t din,
  input  logic                       pop,
  output radio_tx_err_pkg::err_rec_t dout,
  output logic                       valid
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

  radio_tx_err_pkg::err_rec_t mem [DEPTH];

  // Extra MSB tells full from empty
  logic [FIFO_DEPTH_LOG2:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr;
  logic                     full;
  logic                     wr_en;
  logic                     rd_en;

  assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                 (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);
  assign valid = (wr_ptr != rd_ptr);

  // Records arriving while full are lost
  assign wr_en = push && !full;
  assign rd_en = pop && valid;

  always_ff @(posedge radio_clk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= din;
    end
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head shown combinationally
  assign dout = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

  // Reporter only pops a record it has seen
  a_no_pop_empty : assert property (@(posedge radio_clk) disable iff (radio_rst)
    pop |-> valid);

endmodule

`default_nettype wire

/* tx_err_reporter.sv */
`default_nettype none

module tx_err_reporter (
  input  logic                         radio_clk,
  input  logic                         radio_rst,
  input  logic                         rec_valid,
  input  radio_tx_err_pkg::err_rec_t   rec,
  output logic                         pop,
  input  radio_tx_reg_pkg::err_route_t route,
  output radio_tx_err_pkg::err_req_t   err_req,
  input  logic                         err_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT_ACK
  } state_e;

  state_e state;

  // ------------------------------------------------------------------
  // Report sequencer
  // ------------------------------------------------------------------
  // wr and pop pulse in IDLE, the machine leaves on the pulse cycle
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state      <= ST_IDLE;
      err_req.wr <= 1'b0;
      pop        <= 1'b0;
    end else begin
      err_req.wr <= 1'b0;
      pop        <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (err_req.wr) begin
            // Ack on the pulse itself ends the transfer at once
            if (!err_ack) begin
              state <= ST_WAIT_ACK;
            end
          end else if (rec_valid) begin
            err_req.wr <= 1'b1;
            pop        <= 1'b1;
          end
        end
        ST_WAIT_ACK: begin
          if (err_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request payload latched with the pulse
  always_ff @(posedge radio_clk) begin
    if (state == ST_IDLE && !err_req.wr && rec_valid) begin
      err_req.addr       <= route.addr;
      err_req.data       <= 32'(rec.code);
      err_req.req_time   <= rec.err_time;
      err_req.portid     <= route.portid;
      err_req.rem_epid   <= route.rem_epid;
      err_req.rem_portid <= route.rem_portid;
    end
  end

  a_no_wr_waiting : assert property (@(posedge radio_clk) disable iff (radio_rst)
    (state == ST_WAIT_ACK) |-> !err_req.wr);

endmodule

`default_nettype wire
